//--- ber_monitor.sv
// ber_monitor: windowed invalid sync header count driving hi_ber
`timescale 1ns/100ps

module ber_monitor
#(
    parameter int BER_WINDOW   = 1024,
    parameter int HI_BER_LIMIT = 97
)
(
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  pcs_rx_pkg::rx_block_t i_block,
    output logic                  o_hi_ber
);

    localparam int NB_BLK_CNT = $clog2(BER_WINDOW + 1);
    localparam int NB_INV_CNT = $clog2(HI_BER_LIMIT + 1);

    logic [NB_BLK_CNT-1:0] blk_cnt;
    logic [NB_INV_CNT-1:0] inv_cnt;
    logic [NB_INV_CNT-1:0] inv_next;
    logic                  sh_bad;

    always_comb
    begin
        sh_bad = (i_block.sh != pcs_rx_pkg::SH_DATA) && (i_block.sh != pcs_rx_pkg::SH_CTRL);
        if (inv_cnt == NB_INV_CNT'(HI_BER_LIMIT))
            inv_next = inv_cnt;    // saturate at the limit
        else
            inv_next = inv_cnt + NB_INV_CNT'(sh_bad);
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            blk_cnt  <= '0;
            inv_cnt  <= '0;
            o_hi_ber <= 1'b0;
        end
        else if (i_block.valid)
        begin
            if (blk_cnt == NB_BLK_CNT'(BER_WINDOW - 1))
            begin
                o_hi_ber <= (inv_next >= NB_INV_CNT'(HI_BER_LIMIT));    // window closes
                blk_cnt  <= '0;
                inv_cnt  <= '0;
            end
            else
            begin
                blk_cnt <= blk_cnt + 1'b1;
                inv_cnt <= inv_next;
            end
        end
    end

endmodule

//--- block_decoder.sv
// block_decoder: 66-bit block to xgmii word decode with locked error pulse
`timescale 1ns/100ps

module block_decoder
(
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  pcs_rx_pkg::rx_block_t i_block,
    output pcs_rx_pkg::xgmii_t    o_xgmii,
    output logic                  o_decode_error
);

    localparam int NB_DATA = pcs_rx_pkg::NB_PAYLOAD;
    localparam int NB_CTRL = pcs_rx_pkg::NB_CTRL;

    logic [NB_DATA-1:0] dec_data;
    logic [NB_CTRL-1:0] dec_ctrl;
    logic               dec_err;

    always_comb
    begin
        dec_data = {8{pcs_rx_pkg::XC_ERROR}};
        dec_ctrl = '1;
        dec_err  = 1'b1;
        case (i_block.sh)
            pcs_rx_pkg::SH_DATA:
            begin
                dec_data = i_block.payload.bytes;
                dec_ctrl = '0;
                dec_err  = 1'b0;
            end
            pcs_rx_pkg::SH_CTRL:
            begin
                case (i_block.payload.ctrl.block_type)
                    pcs_rx_pkg::BT_IDLE:
                    begin
                        if (i_block.payload.ctrl.body == '0)    // idle body must be clean
                        begin
                            dec_data = {8{pcs_rx_pkg::XC_IDLE}};
                            dec_ctrl = 8'hFF;
                            dec_err  = 1'b0;
                        end
                    end
                    pcs_rx_pkg::BT_START:
                    begin
                        dec_data = {i_block.payload.ctrl.body, pcs_rx_pkg::XC_START};
                        dec_ctrl = 8'h01;
                        dec_err  = 1'b0;
                    end
                    pcs_rx_pkg::BT_TERM7:
                    begin
                        dec_data = {pcs_rx_pkg::XC_TERM, i_block.payload.ctrl.body};
                        dec_ctrl = 8'h80;
                        dec_err  = 1'b0;
                    end
                    default:
                        dec_err = 1'b1;    // unsupported type
                endcase
            end
            default:
                dec_err = 1'b1;    // 00 or 11 header
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        o_xgmii <= '{valid: i_block.valid, data: dec_data, ctrl: dec_ctrl};
        if (i_reset)
            o_xgmii.valid <= 1'b0;
    end

    // errors only count once the lane is locked
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_decode_error <= 1'b0;
        else
            o_decode_error <= i_block.valid && i_block.lock && dec_err;
    end

endmodule

//--- block_sync.sv
// block_sync: sync header lock state machine and registered block output
`timescale 1ns/100ps

module block_sync
#(
    parameter int LOCK_COUNT    = 64,
    parameter int WINDOW_BLOCKS = 1024,
    parameter int INVALID_LIMIT = 16
)
(
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_valid,
    input  pcs_rx_pkg::phy_block_t i_block,
    output pcs_rx_pkg::rx_block_t  o_block,
    output logic                   o_block_lock
);

    localparam int NB_GOOD_CNT = $clog2(LOCK_COUNT + 1);
    localparam int NB_WIN_CNT  = $clog2(WINDOW_BLOCKS + 1);
    localparam int NB_INV_CNT  = $clog2(INVALID_LIMIT + 1);

    logic                   lock_q;
    logic                   lock_next;
    logic [NB_GOOD_CNT-1:0] good_cnt;
    logic [NB_GOOD_CNT-1:0] good_next;
    logic [NB_WIN_CNT-1:0]  win_cnt;
    logic [NB_WIN_CNT-1:0]  win_next;
    logic [NB_INV_CNT-1:0]  inv_cnt;
    logic [NB_INV_CNT-1:0]  inv_next;
    logic [NB_INV_CNT-1:0]  inv_sum;
    logic                   sh_valid;

    always_comb
    begin
        sh_valid  = (i_block.sh == pcs_rx_pkg::SH_DATA) || (i_block.sh == pcs_rx_pkg::SH_CTRL);
        inv_sum   = inv_cnt + NB_INV_CNT'(!sh_valid);
        lock_next = lock_q;
        good_next = good_cnt;
        win_next  = win_cnt;
        inv_next  = inv_cnt;
        if (i_valid)
        begin
            if (!lock_q)
            begin
                if (!sh_valid)
                    good_next = '0;    // restart the run
                else if (good_cnt == NB_GOOD_CNT'(LOCK_COUNT - 1))
                begin
                    lock_next = 1'b1;
                    good_next = '0;
                    win_next  = '0;
                    inv_next  = '0;
                end
                else
                    good_next = good_cnt + 1'b1;
            end
            else if (inv_sum == NB_INV_CNT'(INVALID_LIMIT))
            begin
                // too many bad headers in this window
                lock_next = 1'b0;
                win_next  = '0;
                inv_next  = '0;
            end
            else if (win_cnt == NB_WIN_CNT'(WINDOW_BLOCKS - 1))
            begin
                win_next = '0;
                inv_next = '0;
            end
            else
            begin
                win_next = win_cnt + 1'b1;
                inv_next = inv_sum;
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            lock_q   <= 1'b0;
            good_cnt <= '0;
            win_cnt  <= '0;
            inv_cnt  <= '0;
        end
        else
        begin
            lock_q   <= lock_next;
            good_cnt <= good_next;
            win_cnt  <= win_next;
            inv_cnt  <= inv_next;
        end
    end

    always_ff @(posedge i_clock)
    begin
        o_block <= '{valid: i_valid, lock: lock_next, sh: i_block.sh, payload: i_block.payload};
        if (i_reset)
        begin
            o_block.valid <= 1'b0;
            o_block.lock  <= 1'b0;
        end
    end

    assign o_block_lock = lock_q;

endmodule

//--- build.f
pcs_rx_pkg.sv
block_sync.sv
descrambler.sv
block_decoder.sv
ber_monitor.sv
rx_status_regs.sv
pcs_rx_top.sv
pcs_rx_checker.sv
pcs_rx_tb.sv

//--- descrambler.sv
// descrambler: self-synchronizing 1 + x^39 + x^58 descrambler with bypass
`timescale 1ns/100ps

module descrambler
(
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  pcs_rx_pkg::rx_block_t i_block,
    input  logic                  i_bypass,
    output pcs_rx_pkg::rx_block_t o_block
);

    localparam int NB_HIST = pcs_rx_pkg::SCR_TAP_B;
    localparam int NB_DATA = pcs_rx_pkg::NB_PAYLOAD;

    logic [NB_HIST-1:0]         history;    // newest received bit at the top
    logic [NB_DATA+NB_HIST-1:0] ext;
    logic [NB_DATA-1:0]         descr;

    // bit i sees the received bits 39 and 58 positions before it
    always_comb
    begin
        ext = {i_block.payload, history};
        for (int i = 0; i < NB_DATA; i++)
        begin
            descr[i] = ext[NB_HIST + i]
                     ^ ext[NB_HIST + i - pcs_rx_pkg::SCR_TAP_A]
                     ^ ext[NB_HIST + i - pcs_rx_pkg::SCR_TAP_B];
        end
    end

    // history follows the line even when bypassed
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            history <= '0;
        else if (i_block.valid)
            history <= ext[NB_DATA+NB_HIST-1:NB_DATA];
    end

    always_ff @(posedge i_clock)
    begin
        o_block       <= i_block;
        o_block.payload <= i_bypass ? i_block.payload : descr;
        if (i_reset)
        begin
            o_block.valid <= 1'b0;
            o_block.lock  <= 1'b0;
        end
    end

endmodule

//--- pcs_rx_checker.sv
// bound assertions on output latency, error count and lock after reset
`timescale 1ns/100ps

module pcs_rx_checker
(
    input logic                                  i_clock,
    input logic                                  i_reset,
    input logic                                  i_valid,
    input logic                                  i_read_decode_errors,
    input logic                                  o_xgmii_valid,
    input logic                                  o_block_lock,
    input logic [pcs_rx_pkg::NB_ERROR_COUNT-1:0] o_decode_error_count
);

    int fail_count = 0;

    // three register stages between input and xgmii output
    valid_latency: assert property (@(posedge i_clock) disable iff (i_reset)
        1'b1 |-> ##3 (o_xgmii_valid == $past(i_valid, 3)))
        else
        begin
            fail_count++;
            $error("output valid does not follow input valid by 3 cycles");
        end

    // only a read edge may lower the count
    count_monotonic: assert property (@(posedge i_clock) disable iff (i_reset)
        (o_decode_error_count < $past(o_decode_error_count))
        |-> ($past(i_read_decode_errors) && !$past(i_read_decode_errors, 2)))
        else
        begin
            fail_count++;
            $error("decode error count fell without a read edge");
        end

    lock_after_reset: assert property (@(posedge i_clock) i_reset |=> !o_block_lock)
        else
        begin
            fail_count++;
            $error("block lock set in the cycle after reset");
        end

endmodule

//--- pcs_rx_pkg.sv
// shared widths, header and block type codes, xgmii characters, block and xgmii types
package pcs_rx_pkg;

    localparam int NB_SH          = 2;
    localparam int NB_PAYLOAD     = 64;
    localparam int NB_CTRL        = 8;
    localparam int NB_ERROR_COUNT = 16;

    // sync header codes, 00 and 11 are invalid
    localparam logic [NB_SH-1:0] SH_DATA = 2'b01;
    localparam logic [NB_SH-1:0] SH_CTRL = 2'b10;

    localparam logic [7:0] BT_IDLE  = 8'h1E;    // eight control chars
    localparam logic [7:0] BT_START = 8'h78;    // start in lane 0, D1..D7
    localparam logic [7:0] BT_TERM7 = 8'hFF;    // D0..D6, terminate in lane 7

    localparam logic [7:0] XC_IDLE  = 8'h07;
    localparam logic [7:0] XC_START = 8'hFB;
    localparam logic [7:0] XC_TERM  = 8'hFD;
    localparam logic [7:0] XC_ERROR = 8'hFE;

    // descrambler polynomial 1 + x^39 + x^58
    localparam int SCR_TAP_A = 39;
    localparam int SCR_TAP_B = 58;

    // control view, block type sits in the low byte
    typedef struct packed {
        logic [NB_PAYLOAD-9:0] body;
        logic [7:0]            block_type;
    } block_ctrl_view_t;

    // one 64-bit word, read as data bytes or as type plus body
    typedef union packed {
        logic [NB_PAYLOAD/8-1:0][7:0] bytes;    // byte 0 in low bits
        block_ctrl_view_t             ctrl;
    } block_payload_u;

    // stream between block sync, descrambler and decoder
    typedef struct packed {
        logic                 valid;
        logic                 lock;
        logic [NB_SH-1:0]     sh;
        block_payload_u       payload;
    } rx_block_t;

    // decoded word, ctrl bit set when its byte is a control character
    typedef struct packed {
        logic                  valid;
        logic [NB_PAYLOAD-1:0] data;
        logic [NB_CTRL-1:0]    ctrl;
    } xgmii_t;

    // raw framed block from the pma side
    typedef struct packed {
        logic [NB_SH-1:0]      sh;
        logic [NB_PAYLOAD-1:0] payload;
    } phy_block_t;

endpackage

//--- pcs_rx_tb.sv
// clock, reset, lfsr stimulus, scrambler and decode reference, compare, timeout
`timescale 1ns/100ps

module pcs_rx_tb;

    localparam int N_MIX       = 200;
    localparam int N_BYPASS    = 40;
    localparam int STIM_CYCLES = 30 + 2 * N_MIX + 40 + 3 * 32 + 30 + 3 * 64 + 20
                               + 2 * N_BYPASS + 20;
    localparam int TIMEOUT     = 2 * STIM_CYCLES;

    logic                                  i_clock;
    logic                                  i_reset;
    logic                                  i_valid;
    pcs_rx_pkg::phy_block_t                i_phy_block;
    logic                                  i_descrambler_bypass;
    logic                                  i_read_hi_ber;
    logic                                  i_read_decode_errors;
    pcs_rx_pkg::xgmii_t                    o_xgmii;
    logic                                  o_block_lock;
    logic                                  o_hi_ber;
    logic [pcs_rx_pkg::NB_ERROR_COUNT-1:0] o_decode_error_count;

    logic [31:0]        lfsr = 32'd77072;
    logic [57:0]        tx_hist = '0;    // last 58 line bits with newest on top
    logic               bypass_mode = 1'b0;
    logic               count_errors = 1'b0;
    int                 n_err = 0;
    int                 win_pos = 0;    // next block index in the lock window
    int                 ber_pos = 0;
    int                 cycle_count = 0;
    pcs_rx_pkg::xgmii_t exp_q[$];

    pcs_rx_top #(.LOCK_COUNT(8), .WINDOW_BLOCKS(32), .INVALID_LIMIT(4),
                 .BER_WINDOW(64), .HI_BER_LIMIT(10)) dut_i (.*);

    bind pcs_rx_top pcs_rx_checker checker_i
    (
        .i_clock              (i_clock),
        .i_reset              (i_reset),
        .i_valid              (i_valid),
        .i_read_decode_errors (i_read_decode_errors),
        .o_xgmii_valid        (o_xgmii.valid),
        .o_block_lock         (o_block_lock),
        .o_decode_error_count (o_decode_error_count)
    );

    always #50 i_clock = ~i_clock;

    function automatic logic next_bit();
        logic b;
        b    = lfsr[31];
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return b;
    endfunction

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v[i] = next_bit();
        return v;
    endfunction

    // line bit = data ^ line bits 39 and 58 earlier
    function automatic logic [63:0] scramble(logic [63:0] plain);
        logic [121:0] ext;
        ext        = '0;
        ext[57:0]  = tx_hist;
        for (int i = 0; i < 64; i++)
            ext[58 + i] = plain[i] ^ ext[19 + i] ^ ext[i];
        return ext[121:58];
    endfunction

    function automatic pcs_rx_pkg::xgmii_t ref_decode(logic [1:0] sh, logic [63:0] p);
        pcs_rx_pkg::xgmii_t r;
        r.valid = 1'b1;
        r.data  = {8{pcs_rx_pkg::XC_ERROR}};
        r.ctrl  = 8'hFF;
        if (sh == 2'b01)
        begin
            r.data = p;
            r.ctrl = 8'h00;
        end
        else if (sh == 2'b10)
        begin
            if (p[7:0] == 8'h1E && p[63:8] == '0)
                r.data = {8{pcs_rx_pkg::XC_IDLE}};
            else if (p[7:0] == 8'h78)
            begin
                r.data = {p[63:8], pcs_rx_pkg::XC_START};
                r.ctrl = 8'h01;
            end
            else if (p[7:0] == 8'hFF)
            begin
                r.data = {pcs_rx_pkg::XC_TERM, p[63:8]};
                r.ctrl = 8'h80;
            end
        end
        return r;
    endfunction

    task automatic check_value(string name, logic [127:0] got, logic [127:0] expected);
        if (got !== expected)
        begin
            $display("error: time %0t, %s = %0h, expected %0h", $time, name, got, expected);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic send(logic [1:0] sh, logic [63:0] plain);
        logic [63:0]        line;
        pcs_rx_pkg::xgmii_t e;
        @(posedge i_clock);
        line         = bypass_mode ? plain : scramble(plain);
        tx_hist      = line[63:6];
        e            = ref_decode(sh, plain);
        i_valid     <= 1'b1;
        i_phy_block <= '{sh: sh, payload: line};
        exp_q.push_back(e);
        if (count_errors && e.ctrl == 8'hFF && e.data == {8{pcs_rx_pkg::XC_ERROR}})
            n_err++;
        win_pos = (win_pos + 1) % 32;
        ber_pos = (ber_pos + 1) % 64;
    endtask

    task automatic idle(int n);
        repeat (n)
        begin
            @(posedge i_clock);
            i_valid <= 1'b0;
        end
    endtask

    task automatic settle();
        idle(4);
        @(negedge i_clock);
    endtask

    task automatic send_good();
        send(pcs_rx_pkg::SH_DATA, rand_bits(64));
    endtask

    task automatic send_random_mix(int n);
        logic [1:0] sel;
        for (int i = 0; i < n; i++)
        begin
            sel = 2'(rand_bits(2));
            case (sel)
                2'd0: send_good();
                2'd1: send(pcs_rx_pkg::SH_CTRL, {56'h0, pcs_rx_pkg::BT_IDLE});
                2'd2: send(pcs_rx_pkg::SH_CTRL, {56'(rand_bits(56)), pcs_rx_pkg::BT_START});
                default: send(pcs_rx_pkg::SH_CTRL, {56'(rand_bits(56)), pcs_rx_pkg::BT_TERM7});
            endcase
            if (next_bit())
                idle(1);    // gap in valid
        end
    endtask

    task automatic pad_window();
        while (win_pos != 0)
            send_good();
    endtask

    always @(negedge i_clock)
    begin
        if (dut_i.checker_i.fail_count != 0)
        begin
            $display("an assertion in the bound checker failed");
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
        else if (!i_reset && o_xgmii.valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("output word arrived with no block sent for it");
                $display("SOME TESTS FAILED");
                $fatal(1);
            end
            else
                check_value("o_xgmii", o_xgmii, exp_q.pop_front());
        end
    end

    always @(posedge i_clock)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

    initial
    begin
        i_clock = 1'b0;
        i_reset = 1'b1;
        i_valid = 1'b0;
        i_phy_block = '0;
        i_descrambler_bypass = 1'b0;
        i_read_hi_ber = 1'b0;
        i_read_decode_errors = 1'b0;
        repeat (2) @(posedge i_clock);
        i_reset <= 1'b0;

        // bad header at position 5 restarts the lock count
        repeat (4) send_good();
        send(2'b11, rand_bits(64));
        repeat (7) send_good();
        settle();
        check_value("o_block_lock", o_block_lock, 1'b0);
        send_good();
        win_pos = 0;
        settle();
        check_value("o_block_lock", o_block_lock, 1'b1);

        send_random_mix(N_MIX);
        settle();
        check_value("o_decode_error_count", o_decode_error_count, 16'd0);

        // error blocks and clear on read
        @(posedge i_clock) i_read_decode_errors <= 1'b1;
        @(posedge i_clock) i_read_decode_errors <= 1'b0;
        settle();
        check_value("o_decode_error_count", o_decode_error_count, 16'd0);
        count_errors = 1'b1;
        send(pcs_rx_pkg::SH_CTRL, {56'(rand_bits(56)), 8'h55});
        send_good();
        send(pcs_rx_pkg::SH_CTRL, {56'(rand_bits(56)), 8'h2D});
        send(pcs_rx_pkg::SH_CTRL, {56'h1, pcs_rx_pkg::BT_IDLE});
        send(2'b00, rand_bits(64));
        send(pcs_rx_pkg::SH_CTRL, {56'(rand_bits(56)), 8'hAA});
        count_errors = 1'b0;
        settle();
        check_value("o_decode_error_count", o_decode_error_count, n_err);
        // read edge lands in the same cycle as an error pulse
        send(pcs_rx_pkg::SH_CTRL, {56'(rand_bits(56)), 8'h55});
        idle(2);
        @(posedge i_clock);
        i_valid <= 1'b0;
        i_read_decode_errors <= 1'b1;
        @(posedge i_clock) i_read_decode_errors <= 1'b0;
        settle();
        check_value("o_decode_error_count", o_decode_error_count, 16'd1);

        // three bad headers per window hold lock and four drop it
        pad_window();
        repeat (3) send(2'b11, rand_bits(64));
        pad_window();
        repeat (3) send(2'b00, rand_bits(64));
        settle();
        check_value("o_block_lock", o_block_lock, 1'b1);
        pad_window();
        repeat (4) send(2'b11, rand_bits(64));
        settle();
        check_value("o_block_lock", o_block_lock, 1'b0);

        // dirty ber window then a clean one and a read
        while (ber_pos != 0)
            send_good();
        repeat (10) send(2'b11, rand_bits(64));
        repeat (54) send_good();
        settle();
        check_value("o_hi_ber", o_hi_ber, 1'b1);
        repeat (64) send_good();
        settle();
        check_value("o_hi_ber", o_hi_ber, 1'b1);
        @(posedge i_clock) i_read_hi_ber <= 1'b1;
        @(posedge i_clock) i_read_hi_ber <= 1'b0;
        settle();
        check_value("o_hi_ber", o_hi_ber, 1'b0);
        check_value("o_block_lock", o_block_lock, 1'b1);

        // bypass with plain blocks on the line
        @(posedge i_clock) i_descrambler_bypass <= 1'b1;
        bypass_mode = 1'b1;
        send_random_mix(N_BYPASS);
        settle();

        if (exp_q.size() != 0)
        begin
            $display("%0d expected words never came out of the DUT", exp_q.size());
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
        else if (dut_i.checker_i.fail_count != 0)
        begin
            $display("an assertion in the bound checker failed");
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
        else
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- pcs_rx_top.sv
// pcs_rx_top: single lane 64b/66b receive path, sync to decode plus ber and status
`timescale 1ns/100ps

module pcs_rx_top
#(
    parameter int LOCK_COUNT    = 64,
    parameter int WINDOW_BLOCKS = 1024,
    parameter int INVALID_LIMIT = 16,
    parameter int BER_WINDOW    = 1024,
    parameter int HI_BER_LIMIT  = 97
)
(
    input  logic                                  i_clock,
    input  logic                                  i_reset,
    input  logic                                  i_valid,
    input  pcs_rx_pkg::phy_block_t                i_phy_block,
    input  logic                                  i_descrambler_bypass,
    input  logic                                  i_read_hi_ber,
    input  logic                                  i_read_decode_errors,
    output pcs_rx_pkg::xgmii_t                    o_xgmii,
    output logic                                  o_block_lock,
    output logic                                  o_hi_ber,
    output logic [pcs_rx_pkg::NB_ERROR_COUNT-1:0] o_decode_error_count
);

    pcs_rx_pkg::rx_block_t sync_block;     // block sync to descrambler and ber
    pcs_rx_pkg::rx_block_t descr_block;
    logic                  decode_error;
    logic                  ber_hi;

    block_sync
    #(
        .LOCK_COUNT    (LOCK_COUNT),
        .WINDOW_BLOCKS (WINDOW_BLOCKS),
        .INVALID_LIMIT (INVALID_LIMIT)
    )
    u_block_sync
    (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_block      (i_phy_block),
        .o_block      (sync_block),
        .o_block_lock (o_block_lock)
    );

    descrambler u_descrambler
    (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_block  (sync_block),
        .i_bypass (i_descrambler_bypass),
        .o_block  (descr_block)
    );

    block_decoder u_block_decoder
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_block        (descr_block),
        .o_xgmii        (o_xgmii),
        .o_decode_error (decode_error)
    );

    // runs beside the decode chain, lock independent
    ber_monitor
    #(
        .BER_WINDOW   (BER_WINDOW),
        .HI_BER_LIMIT (HI_BER_LIMIT)
    )
    u_ber_monitor
    (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_block  (sync_block),
        .o_hi_ber (ber_hi)
    );

    rx_status_regs u_rx_status_regs
    (
        .i_clock              (i_clock),
        .i_reset              (i_reset),
        .i_decode_error       (decode_error),
        .i_hi_ber             (ber_hi),
        .i_read_hi_ber        (i_read_hi_ber),
        .i_read_decode_errors (i_read_decode_errors),
        .o_hi_ber             (o_hi_ber),
        .o_decode_error_count (o_decode_error_count)
    );

endmodule

//--- rx_status_regs.sv
// rx_status_regs: clear-on-read decode error counter and latched hi_ber
`timescale 1ns/100ps

module rx_status_regs
(
    input  logic                                  i_clock,
    input  logic                                  i_reset,
    input  logic                                  i_decode_error,
    input  logic                                  i_hi_ber,
    input  logic                                  i_read_hi_ber,
    input  logic                                  i_read_decode_errors,
    output logic                                  o_hi_ber,
    output logic [pcs_rx_pkg::NB_ERROR_COUNT-1:0] o_decode_error_count
);

    localparam int NB_COUNT = pcs_rx_pkg::NB_ERROR_COUNT;

    logic read_hi_ber_d;
    logic read_errors_d;
    logic read_hi_ber_edge;
    logic read_errors_edge;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            read_hi_ber_d <= 1'b0;
            read_errors_d <= 1'b0;
        end
        else
        begin
            read_hi_ber_d <= i_read_hi_ber;
            read_errors_d <= i_read_decode_errors;
        end
    end

    assign read_hi_ber_edge = i_read_hi_ber & ~read_hi_ber_d;
    assign read_errors_edge = i_read_decode_errors & ~read_errors_d;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_decode_error_count <= '0;
        else if (read_errors_edge)
            o_decode_error_count <= NB_COUNT'(i_decode_error);    // reload, keep this cycle's error
        else if (i_decode_error && (o_decode_error_count != '1))
            o_decode_error_count <= o_decode_error_count + 1'b1;
    end

    // sticky until read
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_hi_ber <= 1'b0;
        else if (read_hi_ber_edge)
            o_hi_ber <= i_hi_ber;
        else if (i_hi_ber)
            o_hi_ber <= 1'b1;
    end

endmodule
